/* bench/rv_core_tests.svh */
// program under construction and the events it should produce
word_t      prog_q [$];
word_t      prog_base;
word_t      pause_pc;
word_t      pause_ir;
logic       model_on;
word_t      model_regs [32];
reg_addr_t  exp_addr_q [$];
word_t      exp_data_q [$];
logic [7:0] exp_tx_q [$];

//----------------------------------------------------------------------------
// reference model and encoders
//----------------------------------------------------------------------------
function automatic word_t alu_ref(input logic [2:0] f3, input logic sub,
                                 input word_t a, input word_t b);
    case (f3)
        `F3_ADD: return sub ? (a - b) : (a + b);
        `F3_SLL: return a << b[4:0];
        `F3_XOR: return a ^ b;
        `F3_SRL: return a >> b[4:0];
        `F3_OR:  return a | b;
        default: return a & b;
    endcase
endfunction

task automatic begin_program(input word_t base);
    prog_q.delete();
    exp_addr_q.delete();
    exp_data_q.delete();
    exp_tx_q.delete();
    prog_base = base;
    model_on  = 1'b1;
endtask

// x0 never retires
task automatic retire(input reg_addr_t rd, input word_t value);
    if (model_on && rd != '0) begin
        model_regs[rd] = value;
        exp_addr_q.push_back(rd);
        exp_data_q.push_back(value);
    end
endtask

task automatic emit_op(input logic imm_form, input logic [2:0] f3, input logic sub,
                       input reg_addr_t rd, input reg_addr_t rs1, input reg_addr_t rs2,
                       input logic [11:0] imm);
    word_t b;
    if (imm_form) begin
        b = {{20{imm[11]}}, imm};
        prog_q.push_back({imm, rs1, f3, rd, `OPC_OP_IMM});
    end else begin
        b = model_regs[rs2];
        prog_q.push_back({(sub ? 7'h20 : 7'h00), rs2, rs1, f3, rd, `OPC_OP});
    end
    retire(rd, alu_ref(f3, sub && !imm_form, model_regs[rs1], b));
endtask

task automatic emit_lui(input reg_addr_t rd, input logic [19:0] imm);
    prog_q.push_back({imm, rd, `OPC_LUI});
    retire(rd, {imm, 12'h000});
endtask

task automatic emit_store(input reg_addr_t rs2, input reg_addr_t rs1);
    prog_q.push_back({7'h00, rs2, rs1, 3'b010, 5'h00, `OPC_STORE});
    if (model_on) begin
        exp_tx_q.push_back(model_regs[rs2][7:0]);
    end
endtask

// unsupported opcode that stops retirement
task automatic emit_halt();
    pause_pc = prog_base + (word_t'(prog_q.size()) << 2);
    pause_ir = 32'h0000_007f;
    prog_q.push_back(pause_ir);
    model_on = 1'b0;
endtask

task automatic emit_random_chain(input int n, input reg_addr_t first_rd);
    reg_addr_t  rd;
    reg_addr_t  rs1;
    logic [2:0] f3;
    rs1 = first_rd;
    for (int i = 0; i < n; i++) begin
        case (i % 4)
            0:       f3 = `F3_ADD;
            1:       f3 = `F3_XOR;
            2:       f3 = `F3_OR;
            default: f3 = `F3_AND;
        endcase
        rd = first_rd + reg_addr_t'(i % 4);
        emit_op(1'b1, f3, 1'b0, rd, rs1, '0, 12'($random(seed)));
        rs1 = rd;
    end
endtask

//----------------------------------------------------------------------------
// running a program
//----------------------------------------------------------------------------
task automatic load_and_start();
    for (int i = 0; i < prog_q.size(); i++) begin
        mem[int'(prog_base >> 2) + i] = prog_q[i];
    end
    @(posedge clk);
    #(DRIVE_DELAY);
    start_i      = 1'b1;
    start_addr_i = prog_base;
    got_addr_q.delete();
    got_data_q.delete();
    got_tx_q.delete();
    @(posedge clk);
    #(DRIVE_DELAY);
    start_i = 1'b0;
endtask

task automatic wait_paused(input int max_cycles);
    int cycles;
    cycles = 0;
    while (!paused_o && cycles < max_cycles) begin
        @(posedge clk);
        #(DRIVE_DELAY);
        cycles++;
    end
    if (!paused_o) begin
        report_failure("core never reached the halt instruction");
    end
    // last writeback still has to reach the monitor
    repeat (2) @(posedge clk);
    #(DRIVE_DELAY);
endtask

task automatic check_events();
    check_value("rd_we_o pulses", got_addr_q.size(), exp_addr_q.size());
    check_value("tx_start_o pulses", got_tx_q.size(), exp_tx_q.size());
    for (int i = 0; i < exp_addr_q.size() && i < got_addr_q.size(); i++) begin
        check_value("rd_addr_o", got_addr_q[i], exp_addr_q[i]);
        check_value("rd_data_o", got_data_q[i], exp_data_q[i]);
    end
    for (int i = 0; i < exp_tx_q.size() && i < got_tx_q.size(); i++) begin
        check_value("tx_data_o", got_tx_q[i], exp_tx_q[i]);
    end
    check_value("peek_pc_o", peek_pc_o, pause_pc);
    check_value("peek_ir_o", peek_ir_o, pause_ir);
endtask

//----------------------------------------------------------------------------
// directed tests
//----------------------------------------------------------------------------
task automatic test_reset_state();
    int errs = error_count;
    check_value("rd_we_o", rd_we_o, 1'b0);
    check_value("tx_start_o", tx_start_o, 1'b0);
    check_value("paused_o", paused_o, 1'b0);
    for (int i = 0; i < 10; i++) begin
        check_value("mem_re_o", mem_re_o, 1'b0);
        @(posedge clk);
        #(DRIVE_DELAY);
    end
    end_test("reset_state", errs);
endtask

task automatic test_imm_chain();
    int errs = error_count;
    begin_program(32'h100);
    emit_random_chain(8, 5'd1);
    emit_halt();
    load_and_start();
    wait_paused(200);
    check_events();
    end_test("imm_chain", errs);
endtask

task automatic test_reg_ops();
    int errs = error_count;
    begin_program(32'h200);
    emit_lui(5'd5, 20'($random(seed)));
    emit_op(1'b1, `F3_ADD, 1'b0, 5'd5, 5'd5, '0, 12'($random(seed)));
    emit_lui(5'd6, 20'($random(seed)));
    emit_op(1'b1, `F3_ADD, 1'b0, 5'd6, 5'd6, '0, 12'($random(seed)));
    emit_op(1'b0, `F3_ADD, 1'b0, 5'd7, 5'd5, 5'd6, '0);
    emit_op(1'b0, `F3_ADD, 1'b1, 5'd8, 5'd5, 5'd6, '0);
    emit_op(1'b0, `F3_XOR, 1'b0, 5'd9, 5'd5, 5'd6, '0);
    emit_op(1'b0, `F3_OR, 1'b0, 5'd10, 5'd5, 5'd6, '0);
    emit_op(1'b0, `F3_AND, 1'b0, 5'd11, 5'd5, 5'd6, '0);
    emit_op(1'b0, `F3_SLL, 1'b0, 5'd12, 5'd5, 5'd6, '0);
    emit_op(1'b0, `F3_SRL, 1'b0, 5'd13, 5'd5, 5'd6, '0);
    // x0 as target and then as source
    emit_op(1'b0, `F3_ADD, 1'b0, 5'd0, 5'd5, 5'd6, '0);
    emit_op(1'b0, `F3_ADD, 1'b0, 5'd14, 5'd0, 5'd5, '0);
    emit_halt();
    load_and_start();
    wait_paused(200);
    check_events();
    end_test("reg_ops", errs);
endtask

task automatic test_uart_store();
    int errs = error_count;
    begin_program(32'h300);
    emit_lui(5'd15, 20'($random(seed)));
    emit_op(1'b1, `F3_ADD, 1'b0, 5'd15, 5'd15, '0, 12'($random(seed)));
    emit_store(5'd15, 5'd0);
    emit_halt();
    load_and_start();
    wait_paused(200);
    check_events();
    end_test("uart_store", errs);
endtask

task automatic test_tx_backpressure();
    int errs = error_count;
    begin_program(32'h400);
    emit_store(5'd15, 5'd0);
    emit_random_chain(10, 5'd16);
    emit_halt();
    tx_active_i = 1'b1;
    load_and_start();
    repeat (30) @(posedge clk);
    #(DRIVE_DELAY);
    check_value("rd_we_o pulses", got_addr_q.size(), 0);
    check_value("tx_start_o pulses", got_tx_q.size(), 0);
    check_value("mem_re_o", mem_re_o, 1'b0);
    tx_active_i = 1'b0;
    wait_paused(300);
    check_events();
    end_test("tx_backpressure", errs);
endtask

task automatic test_pause_restart();
    int errs = error_count;
    begin_program(32'h500);
    emit_op(1'b1, `F3_ADD, 1'b0, 5'd20, 5'd0, '0, 12'($random(seed)));
    emit_halt();
    emit_op(1'b1, `F3_ADD, 1'b0, 5'd21, 5'd0, '0, 12'h055);
    emit_op(1'b1, `F3_ADD, 1'b0, 5'd22, 5'd0, '0, 12'h0aa);
    load_and_start();
    wait_paused(200);
    for (int i = 0; i < 10; i++) begin
        check_value("rd_we_o", rd_we_o, 1'b0);
        @(posedge clk);
        #(DRIVE_DELAY);
    end
    check_value("paused_o", paused_o, 1'b1);
    check_events();
    // restart elsewhere with x20 still holding its value
    begin_program(32'h600);
    emit_op(1'b1, `F3_XOR, 1'b0, 5'd23, 5'd20, '0, 12'($random(seed)));
    emit_halt();
    load_and_start();
    check_value("paused_o", paused_o, 1'b0);
    wait_paused(200);
    check_events();
    end_test("pause_restart", errs);
endtask

/* bench/rv_core_tb.sv */
`timescale 1ns/1ps
`include "rv_core_consts.svh"

module rv_core_tb import rv_core_pkg::*; ();

    localparam int CLK_PERIOD  = 100;
    localparam int DRIVE_DELAY = 1;
    localparam int MEM_WORDS   = 1 << `MEM_ADDR_BITS;

    logic                      clk;
    logic                      arst_n_i;
    logic                      start_i;
    word_t                     start_addr_i;
    logic                      mem_re_o;
    logic [`MEM_ADDR_BITS-1:0] mem_addr_o;
    word_t                     mem_rdata_i;
    logic                      tx_active_i;
    logic                      tx_start_o;
    logic [7:0]                tx_data_o;
    logic                      rd_we_o;
    reg_addr_t                 rd_addr_o;
    word_t                     rd_data_o;
    word_t                     peek_pc_o;
    word_t                     peek_ir_o;
    logic                      paused_o;

    word_t      mem [MEM_WORDS];
    logic       read_q;
    word_t      word_q;
    reg_addr_t  got_addr_q [$];
    word_t      got_data_q [$];
    logic [7:0] got_tx_q [$];
    int         error_count;
    int         check_count;
    int         test_count;
    integer     seed;

    rv_core_top uut (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .start_i      (start_i),
        .start_addr_i (start_addr_i),
        .mem_re_o     (mem_re_o),
        .mem_addr_o   (mem_addr_o),
        .mem_rdata_i  (mem_rdata_i),
        .tx_active_i  (tx_active_i),
        .tx_start_o   (tx_start_o),
        .tx_data_o    (tx_data_o),
        .rd_we_o      (rd_we_o),
        .rd_addr_o    (rd_addr_o),
        .rd_data_o    (rd_data_o),
        .peek_pc_o    (peek_pc_o),
        .peek_ir_o    (peek_ir_o),
        .paused_o     (paused_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    //------------------------------------------------------------------------
    // memory model answering one cycle after the read
    //------------------------------------------------------------------------
    always @(posedge clk) begin
        read_q = mem_re_o;
        word_q = mem[mem_addr_o];
        #(DRIVE_DELAY);
        if (read_q) begin
            mem_rdata_i = word_q;
        end
    end

    // writeback and uart monitor
    always @(posedge clk) begin
        if (rd_we_o) begin
            got_addr_q.push_back(rd_addr_o);
            got_data_q.push_back(rd_data_o);
        end
        if (tx_start_o) begin
            got_tx_q.push_back(tx_data_o);
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_failure(input string msg);
        error_count++;
        $display("Failure at %0d ns: %s", $time, msg);
    endtask

    task automatic end_test(input string name, input int errs_before);
        test_count++;
        if (error_count == errs_before) begin
            $display("test %s ok", name);
        end else begin
            $display("test %s %0d errors", name, error_count - errs_before);
        end
    endtask

    `include "rv_core_tests.svh"

    initial begin
        seed         = 32'h5a27;
        error_count  = 0;
        check_count  = 0;
        test_count   = 0;
        clk          = 1'b0;
        arst_n_i     = 1'b0;
        start_i      = 1'b0;
        start_addr_i = '0;
        mem_rdata_i  = '0;
        tx_active_i  = 1'b0;
        // background words carry opcode 0 which is never legal
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = {i[11:0], 20'h00000};
        end
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (5) @(posedge clk);
        #(DRIVE_DELAY);
        arst_n_i = 1'b1;

        test_reset_state();
        test_imm_chain();
        test_reg_ops();
        test_uart_store();
        test_tx_backpressure();
        test_pause_restart();

        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* hdl/rv_core_consts.svh */
`ifndef RV_CORE_CONSTS_SVH
`define RV_CORE_CONSTS_SVH

// widths
`define XLEN            32
`define REG_ADDR_BITS   5
`define PC_BITS         32
`define MEM_ADDR_BITS   12

// instruction queue entries as a power of two
`define QUEUE_DEPTH     4

// major opcodes
`define OPC_OP          7'b0110011
`define OPC_OP_IMM      7'b0010011
`define OPC_LUI         7'b0110111
`define OPC_STORE       7'b0100011

// funct3 for the alu group
`define F3_ADD          3'b000
`define F3_SLL          3'b001
`define F3_XOR          3'b100
`define F3_SRL          3'b101
`define F3_OR           3'b110
`define F3_AND          3'b111

`define RESET_PC        32'h0000_0000

`endif

/* hdl/rv_core_pkg.sv */
`include "rv_core_consts.svh"

package rv_core_pkg;

    typedef logic [`REG_ADDR_BITS-1:0] reg_addr_t;
    typedef logic [`XLEN-1:0]          word_t;

    //------------------------------------------------------------------------
    // instruction formats
    //------------------------------------------------------------------------
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_type_t;

    // offset split around rs2/rs1
    typedef struct packed {
        logic [6:0] imm_hi;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_type_t;

    typedef struct packed {
        logic [19:0] imm;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } u_type_t;

    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
        u_type_t u;
    } instr_word_t;

endpackage

/* hdl/rv_core_top.sv */
`timescale 1ns/1ps
`include "rv_core_consts.svh"

module rv_core_top import rv_core_pkg::*; (
    input  logic                      clk,
    input  logic                      arst_n_i,
    input  logic                      start_i,
    input  word_t                     start_addr_i,
    output logic                      mem_re_o,
    output logic [`MEM_ADDR_BITS-1:0] mem_addr_o,
    input  word_t                     mem_rdata_i,
    input  logic                      tx_active_i,
    output logic                      tx_start_o,
    output logic [7:0]                tx_data_o,
    output logic                      rd_we_o,
    output reg_addr_t                 rd_addr_o,
    output word_t                     rd_data_o,
    output word_t                     peek_pc_o,
    output word_t                     peek_ir_o,
    output logic                      paused_o
);

    logic  push;
    word_t push_instr;
    word_t push_pc;
    logic  room;
    logic  valid;
    word_t head_instr;
    word_t head_pc;
    logic  pop;

    //------------------------------------------------------------------------
    // fetch -> queue -> execute
    //------------------------------------------------------------------------
    rv_fetch u_fetch (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .start_i      (start_i),
        .start_addr_i (start_addr_i),
        .paused_i     (paused_o),
        .room_i       (room),
        .mem_re_o     (mem_re_o),
        .mem_addr_o   (mem_addr_o),
        .mem_rdata_i  (mem_rdata_i),
        .push_o       (push),
        .push_instr_o (push_instr),
        .push_pc_o    (push_pc)
    );

    rv_instr_queue u_queue (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .flush_i      (start_i),
        .push_i       (push),
        .push_instr_i (push_instr),
        .push_pc_i    (push_pc),
        .room_o       (room),
        .pop_i        (pop),
        .valid_o      (valid),
        .head_instr_o (head_instr),
        .head_pc_o    (head_pc)
    );

    rv_execute u_execute (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .start_i     (start_i),
        .valid_i     (valid),
        .instr_i     (head_instr),
        .pc_i        (head_pc),
        .pop_o       (pop),
        .paused_o    (paused_o),
        .tx_active_i (tx_active_i),
        .tx_start_o  (tx_start_o),
        .tx_data_o   (tx_data_o),
        .rd_we_o     (rd_we_o),
        .rd_addr_o   (rd_addr_o),
        .rd_data_o   (rd_data_o),
        .peek_pc_o   (peek_pc_o),
        .peek_ir_o   (peek_ir_o)
    );

endmodule

/* hdl/rv_execute.sv */
`timescale 1ns/1ps
`include "rv_core_consts.svh"

module rv_execute import rv_core_pkg::*; (
    input  logic        clk,
    input  logic        arst_n_i,
    input  logic        start_i,
    input  logic        valid_i,
    input  instr_word_t instr_i,
    input  word_t       pc_i,
    output logic        pop_o,
    output logic        paused_o,
    input  logic        tx_active_i,
    output logic        tx_start_o,
    output logic [7:0]  tx_data_o,
    output logic        rd_we_o,
    output reg_addr_t   rd_addr_o,
    output word_t       rd_data_o,
    output word_t       peek_pc_o,
    output word_t       peek_ir_o
);

    logic      is_op;
    logic      is_op_imm;
    logic      is_lui;
    logic      is_store;
    logic      f3_legal;
    logic      legal;
    logic      do_sub;
    logic      store_stall;
    logic      wb_en;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    reg_addr_t rd_addr;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     operand_b;
    word_t     alu_out;
    word_t     result;
    logic [4:0] shamt;

    //------------------------------------------------------------------------
    // decode
    //------------------------------------------------------------------------
    assign is_op     = (instr_i.r.opcode == `OPC_OP);
    assign is_op_imm = (instr_i.i.opcode == `OPC_OP_IMM);
    assign is_lui    = (instr_i.u.opcode == `OPC_LUI);
    assign is_store  = (instr_i.s.opcode == `OPC_STORE);

    always_comb begin
        case (instr_i.r.funct3)
            `F3_ADD, `F3_SLL, `F3_XOR,
            `F3_SRL, `F3_OR, `F3_AND: f3_legal = 1'b1;
            default:                  f3_legal = 1'b0;
        endcase
    end

    assign legal = ((is_op || is_op_imm) && f3_legal) || is_lui || is_store;

    assign rs1_addr = instr_i.r.rs1;
    assign rs2_addr = instr_i.r.rs2;
    assign rd_addr  = instr_i.r.rd;

    rv_reg_file u_reg_file (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (wb_en),
        .wr_addr_i  (rd_addr),
        .wr_data_i  (result)
    );

    //------------------------------------------------------------------------
    // alu
    //------------------------------------------------------------------------
    assign operand_b = is_op ? rs2_data : {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
    // funct7 only exists in the R view
    assign do_sub    = is_op && instr_i.r.funct7[5];
    assign shamt     = operand_b[4:0];

    always_comb begin
        case (instr_i.r.funct3)
            `F3_ADD: alu_out = do_sub ? (rs1_data - operand_b) : (rs1_data + operand_b);
            `F3_SLL: alu_out = rs1_data << shamt;
            `F3_XOR: alu_out = rs1_data ^ operand_b;
            `F3_SRL: alu_out = rs1_data >> shamt;
            `F3_OR:  alu_out = rs1_data | operand_b;
            `F3_AND: alu_out = rs1_data & operand_b;
            default: alu_out = rs1_data + operand_b;
        endcase
    end

    assign result = is_lui ? {instr_i.u.imm, 12'h000} : alu_out;

    //------------------------------------------------------------------------
    // issue control
    //------------------------------------------------------------------------
    // hold a store until the transmitter is idle and the last byte has left
    assign store_stall = is_store && (tx_active_i || tx_start_o);
    assign pop_o       = valid_i && !paused_o && !start_i && !store_stall;
    assign wb_en       = pop_o && legal && !is_store && (rd_addr != '0);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_we_o    <= 1'b0;
            tx_start_o <= 1'b0;
            paused_o   <= 1'b0;
        end else begin
            rd_we_o    <= wb_en;
            tx_start_o <= pop_o && is_store;
            if (start_i) begin
                paused_o <= 1'b0;
            end else if (pop_o && !legal) begin
                paused_o <= 1'b1;
            end
        end
    end

    // result and debug registers
    always_ff @(posedge clk) begin
        if (wb_en) begin
            rd_addr_o <= rd_addr;
            rd_data_o <= result;
        end
        if (pop_o && is_store) begin
            tx_data_o <= rs2_data[7:0];
        end
        if (pop_o) begin
            peek_pc_o <= pc_i;
            peek_ir_o <= instr_i;
        end
    end

endmodule

/* hdl/rv_fetch.sv */
`timescale 1ns/1ps
`include "rv_core_consts.svh"

module rv_fetch import rv_core_pkg::*; (
    input  logic                      clk,
    input  logic                      arst_n_i,
    input  logic                      start_i,
    input  word_t                     start_addr_i,
    input  logic                      paused_i,
    input  logic                      room_i,
    output logic                      mem_re_o,
    output logic [`MEM_ADDR_BITS-1:0] mem_addr_o,
    input  word_t                     mem_rdata_i,
    output logic                      push_o,
    output word_t                     push_instr_o,
    output word_t                     push_pc_o
);

    word_t pc;
    word_t pend_pc;
    logic  running;
    logic  pending;

    // one read per cycle while the queue can take it
    assign mem_re_o   = running && room_i && !paused_i;
    assign mem_addr_o = pc[`MEM_ADDR_BITS+1:2];

    //------------------------------------------------------------------------
    // pc and read tracking
    //------------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc      <= `RESET_PC;
            running <= 1'b0;
            pending <= 1'b0;
        end else if (start_i) begin
            // restart drops whatever read is still returning
            pc      <= {start_addr_i[`PC_BITS-1:2], 2'b00};
            running <= 1'b1;
            pending <= 1'b0;
        end else begin
            pending <= mem_re_o;
            if (mem_re_o) begin
                pc <= pc + 32'd4;
            end
        end
    end

    // address of the read in flight
    always_ff @(posedge clk) begin
        if (mem_re_o) begin
            pend_pc <= pc;
        end
    end

    // data comes back one cycle after the read
    assign push_o       = pending;
    assign push_instr_o = mem_rdata_i;
    assign push_pc_o    = pend_pc;

endmodule

/* hdl/rv_instr_queue.sv */
`timescale 1ns/1ps
`include "rv_core_consts.svh"

module rv_instr_queue import rv_core_pkg::*; #(
    parameter int DEPTH = `QUEUE_DEPTH
) (
    input  logic  clk,
    input  logic  arst_n_i,
    input  logic  flush_i,
    input  logic  push_i,
    input  word_t push_instr_i,
    input  word_t push_pc_i,
    output logic  room_o,
    input  logic  pop_i,
    output logic  valid_o,
    output word_t head_instr_o,
    output word_t head_pc_o
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;
    localparam logic [CNT_W-1:0] ROOM_MAX = CNT_W'(DEPTH - 2);

    word_t             instr_mem [DEPTH];
    word_t             pc_mem    [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              do_pop;

    assign valid_o      = (count != '0);
    assign do_pop       = pop_i && valid_o;
    // two free slots leave one for the read in flight
    assign room_o       = (count <= ROOM_MAX);
    assign head_instr_o = instr_mem[rd_ptr];
    assign head_pc_o    = pc_mem[rd_ptr];

    //------------------------------------------------------------------------
    // pointers and count
    //------------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_i, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (push_i) begin
            instr_mem[wr_ptr] <= push_instr_i;
            pc_mem[wr_ptr]    <= push_pc_i;
        end
    end

endmodule

/* hdl/rv_reg_file.sv */
`timescale 1ns/1ps
`include "rv_core_consts.svh"

module rv_reg_file import rv_core_pkg::*; (
    input  logic      clk,
    input  logic      arst_n_i,
    input  reg_addr_t rs1_addr_i,
    input  reg_addr_t rs2_addr_i,
    output word_t     rs1_data_o,
    output word_t     rs2_data_o,
    input  logic      we_i,
    input  reg_addr_t wr_addr_i,
    input  word_t     wr_data_i
);

    localparam int NUM_REGS = 1 << `REG_ADDR_BITS;

    word_t regs [NUM_REGS];

    // x0 reads as zero whatever is stored
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (wr_addr_i != '0)) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the core testbench with Verilator, result taken from the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f tb.f --top-module rv_core_tb -o rv_core_tb \
    && ./obj_dir/rv_core_tb > sim.log 2>&1 \
    || { echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -qx "Testbench passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* tb.f */
+incdir+hdl
+incdir+bench
hdl/rv_core_pkg.sv
hdl/rv_fetch.sv
hdl/rv_instr_queue.sv
hdl/rv_reg_file.sv
hdl/rv_execute.sv
hdl/rv_core_top.sv
bench/rv_core_tb.sv
